// File: rv_pkg.sv
package rv_pkg;

    ////////////////////
    // Widths and constants
    ////////////////////

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int CSR_AW = 12;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] WFI_INSN  = 32'h1050_0073;
    localparam logic [XLEN-1:0] MRET_INSN = 32'h3020_0073;

    ////////////////////
    // Encodings
    ////////////////////

    typedef enum logic [6:0] {
        OP_R_M   = 7'b0110011,  // Register ops, MUL/DIV included.
        OP_I     = 7'b0010011,
        OP_L     = 7'b0000011,
        OP_S     = 7'b0100011,
        OP_B     = 7'b1100011,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_CSR   = 7'b1110011   // SYSTEM, also WFI and MRET.
    } opcode_e;

    typedef enum logic [2:0] {
        ST_REQ,     // Request on the memory bus.
        ST_WAIT,    // Waiting for the response.
        ST_HOLD,    // Word held, decode side busy.
        ST_STALL,   // Waiting for a redirect from execute.
        ST_SLEEP    // WFI, waiting for irq.
    } fetch_state_e;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_add4;
        logic [XLEN-1:0]   pc_add_imm;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [CSR_AW-1:0] csr_addr;
        logic              mul;
        logic              wfi;
        logic              mret;
        logic              mem_read;
        logic              mem_store;
        logic              reg_write;
        logic              op1_is_reg;
        logic              op2_is_reg;
        logic              branch_jump;
        logic              csr_write;
    } decoded_t;

endpackage

// File: insn_if.sv
`timescale 1ns/100ps

interface insn_if import rv_pkg::*; ();

    logic            valid;
    logic            ready;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;

    // Fetch side owns the word and its address.
    modport fetch (
        output valid,
        output pc,
        output insn,
        input  ready
    );

    modport decode (
        output ready,
        input  valid,
        input  pc,
        input  insn
    );

endinterface

// File: pc_gen.sv
`timescale 1ns/100ps

module pc_gen import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            step_i,
    input  logic            load_i,
    input  logic [XLEN-1:0] target_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;

    always_comb begin
        pc_d = pc_q;
        if (load_i) begin
            pc_d = target_i;             // Load beats step.
        end else if (step_i) begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: fetch_fsm.sv
`timescale 1ns/100ps

module fetch_fsm import rv_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    output logic            req_valid_o,
    input  logic            req_ready_i,
    output logic [XLEN-1:0] req_addr_o,
    input  logic            rsp_valid_i,
    input  logic [XLEN-1:0] rsp_data_i,
    input  decoded_t        dec_i,
    input  logic            redirect_valid_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic            irq_i,
    input  logic [XLEN-1:0] pc_i,
    output logic            pc_step_o,
    output logic            pc_load_o,
    output logic [XLEN-1:0] pc_target_o,
    insn_if.fetch           insn
);

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    logic            req_valid_q;
    logic [XLEN-1:0] hold_q;
    logic            fire;
    logic            is_jal;
    logic            is_stall;

    assign fire     = insn.valid && insn.ready;
    assign is_jal   = dec_i.branch_jump && !dec_i.op1_is_reg;  // JAL has no register operand.
    assign is_stall = dec_i.branch_jump && dec_i.op1_is_reg;   // Branch or JALR.

    assign insn.valid  = ((state_q == ST_WAIT) && rsp_valid_i) || (state_q == ST_HOLD);
    assign insn.insn   = (state_q == ST_HOLD) ? hold_q : rsp_data_i;
    assign insn.pc     = pc_i;                                 // pc only moves on transfer.
    assign req_valid_o = req_valid_q;
    assign req_addr_o  = pc_i;

    ////////////////////
    // Next state and next pc
    ////////////////////

    always_comb begin
        state_d     = state_q;
        pc_step_o   = 1'b0;
        pc_load_o   = 1'b0;
        pc_target_o = dec_i.pc_add_imm;
        case (state_q)
            ST_REQ: begin
                if (req_valid_q && req_ready_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT, ST_HOLD: begin
                if (fire) begin
                    state_d = ST_REQ;
                    if (dec_i.mret) begin
                        pc_load_o   = 1'b1;
                        pc_target_o = mepc_i;
                    end else if (dec_i.wfi) begin
                        pc_step_o = 1'b1;
                        state_d   = ST_SLEEP;
                    end else if (is_stall) begin
                        state_d = ST_STALL;
                    end else if (is_jal) begin
                        pc_load_o = 1'b1;
                    end else begin
                        pc_step_o = 1'b1;
                    end
                end else if (insn.valid) begin
                    state_d = ST_HOLD;           // Decode side full, keep the word.
                end
            end
            ST_STALL: begin
                if (redirect_valid_i) begin
                    pc_load_o   = 1'b1;
                    pc_target_o = redirect_pc_i;
                    state_d     = ST_REQ;
                end
            end
            ST_SLEEP: begin
                if (irq_i) begin
                    state_d = ST_REQ;
                end
            end
            default: state_d = ST_REQ;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_REQ;
            req_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_valid_q <= (state_d == ST_REQ);  // Request starts the cycle after entry.
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_WAIT) && rsp_valid_i) begin
            hold_q <= rsp_data_i;
        end
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage import rv_pkg::*; (
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] insn_i,
    output decoded_t        dec_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1;
    logic            is_wfi;
    logic            is_mret;
    logic            csr_rs1_form;
    logic [XLEN-1:0] imm;

    assign opcode  = opcode_e'(insn_i[6:0]);
    assign funct3  = insn_i[14:12];
    assign funct7  = insn_i[31:25];
    assign rs1     = insn_i[19:15];
    assign is_wfi  = (insn_i == WFI_INSN);
    assign is_mret = (insn_i == MRET_INSN);

    // CSRRW/CSRRS/CSRRC read rs1 only when it is not x0.
    assign csr_rs1_form = (opcode == OP_CSR) && (funct3 inside {3'b001, 3'b010, 3'b011})
                          && (rs1 != 5'd0);

    ////////////////////
    // Immediate
    ////////////////////

    always_comb begin
        case (opcode)
            OP_I, OP_L, OP_JALR: begin
                imm = {{20{insn_i[31]}}, insn_i[31:20]};
            end
            OP_S: begin
                imm = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
            end
            OP_B: begin
                imm = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25],
                       insn_i[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {insn_i[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20],
                       insn_i[30:21], 1'b0};
            end
            OP_CSR:  imm = {27'b0, rs1};     // zimm.
            default: imm = '0;
        endcase
    end

    ////////////////////
    // Fields and flags
    ////////////////////

    always_comb begin
        dec_o.pc          = pc_i;
        dec_o.pc_add4     = pc_i + 32'd4;
        dec_o.pc_add_imm  = pc_i + imm;
        dec_o.imm         = imm;
        dec_o.rd          = insn_i[11:7];
        dec_o.rs1         = rs1;
        dec_o.rs2         = insn_i[24:20];
        dec_o.csr_addr    = insn_i[31:20];
        dec_o.mul         = (opcode == OP_R_M) && (funct7 == 7'b0000001);
        dec_o.wfi         = is_wfi;
        dec_o.mret        = is_mret;
        dec_o.mem_read    = (opcode == OP_L);
        dec_o.mem_store   = (opcode == OP_S);
        dec_o.reg_write   = opcode inside {OP_L, OP_R_M, OP_I, OP_JAL, OP_JALR,
                                           OP_LUI, OP_AUIPC, OP_CSR};
        dec_o.op1_is_reg  = (opcode inside {OP_R_M, OP_I, OP_S, OP_L, OP_JALR, OP_B})
                            || csr_rs1_form;
        dec_o.op2_is_reg  = opcode inside {OP_R_M, OP_S, OP_B};
        dec_o.branch_jump = opcode inside {OP_B, OP_JAL, OP_JALR};
        dec_o.csr_write   = (opcode == OP_CSR) && !is_wfi && !is_mret;
    end

endmodule

// File: decode_out_reg.sv
`timescale 1ns/100ps

module decode_out_reg import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    insn_if.decode   insn,
    input  decoded_t dec_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output decoded_t out_o
);

    logic     valid_q;
    decoded_t data_q;
    logic     load;

    // Free slot, or the held entry leaves this cycle.
    assign insn.ready = !valid_q || out_ready_i;
    assign load       = insn.valid && insn.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= dec_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

endmodule

// File: rv_frontend_top.sv
`timescale 1ns/100ps

module rv_frontend_top import rv_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Instruction memory.
    output logic              imem_req_valid_o,
    input  logic              imem_req_ready_i,
    output logic [XLEN-1:0]   imem_addr_o,
    input  logic              imem_rsp_valid_i,
    input  logic [XLEN-1:0]   imem_rsp_data_i,
    // From execute.
    input  logic              redirect_valid_i,
    input  logic [XLEN-1:0]   redirect_pc_i,
    input  logic [XLEN-1:0]   mepc_i,
    input  logic              irq_i,
    // To execute.
    output logic              dec_valid_o,
    input  logic              dec_ready_i,
    output logic [XLEN-1:0]   dec_pc_o,
    output logic [XLEN-1:0]   dec_pc_add4_o,
    output logic [XLEN-1:0]   dec_pc_add_imm_o,
    output logic [XLEN-1:0]   dec_imm_o,
    output logic [REG_AW-1:0] dec_rd_o,
    output logic [REG_AW-1:0] dec_rs1_o,
    output logic [REG_AW-1:0] dec_rs2_o,
    output logic [CSR_AW-1:0] dec_csr_addr_o,
    output logic              dec_mul_o,
    output logic              dec_wfi_o,
    output logic              dec_mret_o,
    output logic              dec_mem_read_o,
    output logic              dec_mem_store_o,
    output logic              dec_reg_write_o,
    output logic              dec_op1_is_reg_o,
    output logic              dec_op2_is_reg_o,
    output logic              dec_branch_jump_o,
    output logic              dec_csr_write_o
);

    logic            pc_step;
    logic            pc_load;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] pc;
    decoded_t        dec;
    decoded_t        dec_out;

    insn_if insn_bus ();

    pc_gen pc_gen_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .step_i   (pc_step),
        .load_i   (pc_load),
        .target_i (pc_target),
        .pc_o     (pc)
    );

    fetch_fsm fetch_fsm_inst (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .req_valid_o      (imem_req_valid_o),
        .req_ready_i      (imem_req_ready_i),
        .req_addr_o       (imem_addr_o),
        .rsp_valid_i      (imem_rsp_valid_i),
        .rsp_data_i       (imem_rsp_data_i),
        .dec_i            (dec),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .mepc_i           (mepc_i),
        .irq_i            (irq_i),
        .pc_i             (pc),
        .pc_step_o        (pc_step),
        .pc_load_o        (pc_load),
        .pc_target_o      (pc_target),
        .insn             (insn_bus.fetch)
    );

    // Decode sits on the bus and feeds both sides.
    decode_stage decode_stage_inst (
        .pc_i   (insn_bus.pc),
        .insn_i (insn_bus.insn),
        .dec_o  (dec)
    );

    decode_out_reg decode_out_reg_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .insn        (insn_bus.decode),
        .dec_i       (dec),
        .out_valid_o (dec_valid_o),
        .out_ready_i (dec_ready_i),
        .out_o       (dec_out)
    );

    assign dec_pc_o          = dec_out.pc;
    assign dec_pc_add4_o     = dec_out.pc_add4;
    assign dec_pc_add_imm_o  = dec_out.pc_add_imm;
    assign dec_imm_o         = dec_out.imm;
    assign dec_rd_o          = dec_out.rd;
    assign dec_rs1_o         = dec_out.rs1;
    assign dec_rs2_o         = dec_out.rs2;
    assign dec_csr_addr_o    = dec_out.csr_addr;
    assign dec_mul_o         = dec_out.mul;
    assign dec_wfi_o         = dec_out.wfi;
    assign dec_mret_o        = dec_out.mret;
    assign dec_mem_read_o    = dec_out.mem_read;
    assign dec_mem_store_o   = dec_out.mem_store;
    assign dec_reg_write_o   = dec_out.reg_write;
    assign dec_op1_is_reg_o  = dec_out.op1_is_reg;
    assign dec_op2_is_reg_o  = dec_out.op2_is_reg;
    assign dec_branch_jump_o = dec_out.branch_jump;
    assign dec_csr_write_o   = dec_out.csr_write;

endmodule

// File: rv_frontend_checker.sv
`timescale 1ns/100ps

module rv_frontend_checker import rv_pkg::*; (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            req_valid_i,
    input logic            req_ready_i,
    input logic [XLEN-1:0] req_addr_i,
    input logic            rsp_valid_i,
    input logic            dec_valid_i,
    input logic            dec_ready_i,
    input logic [XLEN-1:0] dec_pc_i,
    input logic [XLEN-1:0] dec_imm_i
);

    logic pending_q;  // Request accepted, response not yet seen.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            pending_q <= 1'b1;
        end else if (rsp_valid_i) begin
            pending_q <= 1'b0;
        end
    end

    ////////////////////
    // Properties
    ////////////////////

    reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !dec_valid_i && !req_valid_i)
        else $error("valid output high during reset");

    dec_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dec_valid_i && !dec_ready_i |=> dec_valid_i && $stable(dec_pc_i) && $stable(dec_imm_i))
        else $error("decoded output changed before it was taken");

    req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_addr_i))
        else $error("memory request dropped or changed before acceptance");

    one_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pending_q |-> !req_valid_i)
        else $error("second memory request while a response is pending");

endmodule

// File: tb_rv_frontend.sv
`timescale 1ns/100ps

module tb_rv_frontend import rv_pkg::*; ();

    localparam int          NUM_STEPS = 14;
    localparam logic [31:0] MEPC      = 32'h0000_0080;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] insn;
        logic [3:0]  hold;   // Cycles of dec_ready_i low once valid.
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] csr;
        logic [9:0]  flags;  // mul wfi mret rd st wr op1 op2 bj csr.
    } step_t;

    logic              clk_i = 1'b0;
    logic              arst_n_i;
    logic              imem_req_valid_o;
    logic              imem_req_ready_i;
    logic [XLEN-1:0]   imem_addr_o;
    logic              imem_rsp_valid_i;
    logic [XLEN-1:0]   imem_rsp_data_i;
    logic              redirect_valid_i;
    logic [XLEN-1:0]   redirect_pc_i;
    logic [XLEN-1:0]   mepc_i;
    logic              irq_i;
    logic              dec_valid_o;
    logic              dec_ready_i;
    logic [XLEN-1:0]   dec_pc_o;
    logic [XLEN-1:0]   dec_pc_add4_o;
    logic [XLEN-1:0]   dec_pc_add_imm_o;
    logic [XLEN-1:0]   dec_imm_o;
    logic [REG_AW-1:0] dec_rd_o;
    logic [REG_AW-1:0] dec_rs1_o;
    logic [REG_AW-1:0] dec_rs2_o;
    logic [CSR_AW-1:0] dec_csr_addr_o;
    logic              dec_mul_o;
    logic              dec_wfi_o;
    logic              dec_mret_o;
    logic              dec_mem_read_o;
    logic              dec_mem_store_o;
    logic              dec_reg_write_o;
    logic              dec_op1_is_reg_o;
    logic              dec_op2_is_reg_o;
    logic              dec_branch_jump_o;
    logic              dec_csr_write_o;

    step_t        steps [NUM_STEPS];
    int           num_filled   = 0;
    int           cur_step     = 0;
    int           step_fails   = 0;
    int           fetch_errors = 0;
    int           passed       = 0;
    int           failed       = 0;
    integer       seed         = 31252;
    logic [9:0]   flags_now;
    logic [164:0] out_bus;

    assign flags_now = {dec_mul_o, dec_wfi_o, dec_mret_o, dec_mem_read_o, dec_mem_store_o,
                        dec_reg_write_o, dec_op1_is_reg_o, dec_op2_is_reg_o,
                        dec_branch_jump_o, dec_csr_write_o};
    assign out_bus   = {dec_pc_o, dec_pc_add4_o, dec_pc_add_imm_o, dec_imm_o, dec_rd_o,
                        dec_rs1_o, dec_rs2_o, dec_csr_addr_o, flags_now};

    rv_frontend_top rv_frontend_top_inst (.*);

    bind rv_frontend_top rv_frontend_checker rv_frontend_checker_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (imem_req_valid_o),
        .req_ready_i (imem_req_ready_i),
        .req_addr_i  (imem_addr_o),
        .rsp_valid_i (imem_rsp_valid_i),
        .dec_valid_i (dec_valid_o),
        .dec_ready_i (dec_ready_i),
        .dec_pc_i    (dec_pc_o),
        .dec_imm_i   (dec_imm_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic add_step(input logic [31:0] addr, input logic [31:0] insn, input int hold,
                            input logic [31:0] imm, input int rd, input int rs1, input int rs2,
                            input logic [11:0] csr, input logic [9:0] flags);
        steps[num_filled] = {addr, insn, 4'(hold), imm, 5'(rd), 5'(rs1), 5'(rs2), csr, flags};
        num_filled++;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: step %0d %s is %h, expected %h",
                     $time, cur_step, name, got, exp);
            step_fails++;
        end
    endtask

    task automatic expect_no_fetch(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            #1;
            if (imem_req_valid_o) begin
                $display("Error at %0t: step %0d, a memory request came out while fetch was stopped",
                         $time, cur_step);
                step_fails++;
            end
        end
    endtask

    task automatic lookup_word(input logic [31:0] addr, output logic [31:0] word);
        logic found;
        found = 1'b0;
        word  = '0;
        for (int k = 0; k < NUM_STEPS; k++) begin
            if (steps[k].addr == addr) begin
                word  = steps[k].insn;
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Error at %0t: fetch from address %h, which is not in the program",
                     $time, addr);
            fetch_errors++;
        end
    endtask

    ////////////////////
    // Instruction memory
    ////////////////////

    initial begin : imem_model
        logic [31:0] addr;
        logic [31:0] word;
        int          delay;
        imem_req_ready_i = 1'b0;
        imem_rsp_valid_i = 1'b0;
        imem_rsp_data_i  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (imem_req_valid_o) begin
                addr  = imem_addr_o;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                end
                imem_req_ready_i = 1'b1;
                @(posedge clk_i);
                #1;
                imem_req_ready_i = 1'b0;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                end
                lookup_word(addr, word);
                imem_rsp_valid_i = 1'b1;
                imem_rsp_data_i  = word;
                @(posedge clk_i);
                #1;
                imem_rsp_valid_i = 1'b0;
                imem_rsp_data_i  = '0;
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : main
        logic [164:0] snap;
        int           i;
        arst_n_i         = 1'b1;
        dec_ready_i      = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        mepc_i           = MEPC;
        irq_i            = 1'b0;

        add_step(32'h0000_0000, 32'h0220_81B3, 0, 32'h0000_0000, 3, 1, 2, 12'h022,
                 10'b1000011100); // mul x3, x1, x2.
        add_step(32'h0000_0004, 32'hFFD0_8293, 2, 32'hFFFF_FFFD, 5, 1, 29, 12'hFFD,
                 10'b0000011000); // addi x5, x1, -3.
        add_step(32'h0000_0008, 32'h0081_2303, 3, 32'h0000_0008, 6, 2, 8, 12'h008,
                 10'b0001011000); // lw x6, 8(x2).
        add_step(32'h0000_000C, 32'hFE71_2E23, 0, 32'hFFFF_FFFC, 28, 2, 7, 12'hFE7,
                 10'b0000101100); // sw x7, -4(x2).
        add_step(32'h0000_0010, 32'h1234_5437, 1, 32'h1234_5000, 8, 8, 3, 12'h123,
                 10'b0000010000); // lui x8.
        add_step(32'h0000_0014, 32'h0000_1497, 0, 32'h0000_1000, 9, 0, 0, 12'h000,
                 10'b0000010000); // auipc x9.
        add_step(32'h0000_0018, 32'h0100_00EF, 0, 32'h0000_0010, 1, 0, 16, 12'h010,
                 10'b0000010010); // jal x1, +16.
        add_step(32'h0000_0028, 32'hABCD_E07B, 1, 32'h0000_0000, 0, 27, 28, 12'hABC,
                 10'b0000000000); // Unknown opcode.
        add_step(32'h0000_002C, 32'h0020_8463, 0, 32'h0000_0008, 8, 1, 2, 12'h002,
                 10'b0000001110); // beq, then redirect.
        add_step(32'h0000_0040, 32'h3005_9573, 0, 32'h0000_000B, 10, 11, 0, 12'h300,
                 10'b0000011001); // csrrw x10, x11.
        add_step(32'h0000_0044, 32'h3402_D673, 2, 32'h0000_0005, 12, 5, 0, 12'h340,
                 10'b0000010001); // csrrwi x12, 5.
        add_step(32'h0000_0048, 32'h1050_0073, 0, 32'h0000_0000, 0, 0, 5, 12'h105,
                 10'b0100010000); // wfi
        add_step(32'h0000_004C, 32'h3020_0073, 1, 32'h0000_0000, 0, 0, 2, 12'h302,
                 10'b0010010000); // mret
        add_step(32'h0000_0080, 32'h0000_8067, 0, 32'h0000_0000, 0, 1, 0, 12'h000,
                 10'b0000011010); // jalr x0, 0(x1).

        #1;
        arst_n_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        for (i = 0; i < NUM_STEPS; i++) begin
            cur_step   = i;
            step_fails = 0;
            while (!dec_valid_o) begin
                @(posedge clk_i);
                #1;
            end
            snap = out_bus;
            repeat (steps[i].hold) begin
                @(posedge clk_i);
                #1;
                if (!dec_valid_o || out_bus !== snap) begin
                    $display("FAILED at %0t: step %0d outputs moved while dec_ready_i was low",
                             $time, i);
                    step_fails++;
                end
            end
            check_field("pc", dec_pc_o, steps[i].addr);
            check_field("pc_add4", dec_pc_add4_o, steps[i].addr + 32'd4);
            check_field("pc_add_imm", dec_pc_add_imm_o, steps[i].addr + steps[i].imm);
            check_field("imm", dec_imm_o, steps[i].imm);
            check_field("rd", 32'(dec_rd_o), 32'(steps[i].rd));
            check_field("rs1", 32'(dec_rs1_o), 32'(steps[i].rs1));
            check_field("rs2", 32'(dec_rs2_o), 32'(steps[i].rs2));
            check_field("csr_addr", 32'(dec_csr_addr_o), 32'(steps[i].csr));
            check_field("flags", 32'(flags_now), 32'(steps[i].flags));
            dec_ready_i = 1'b1;
            @(posedge clk_i);
            #1;
            dec_ready_i = 1'b0;

            // Branch and JALR wait for execute, WFI for the interrupt.
            if (steps[i].flags[1] && steps[i].flags[3] && i < NUM_STEPS - 1) begin
                expect_no_fetch(4);
                redirect_pc_i    = steps[i+1].addr;
                redirect_valid_i = 1'b1;
                @(posedge clk_i);
                #1;
                redirect_valid_i = 1'b0;
            end else if (steps[i].flags[8]) begin
                expect_no_fetch(4);
                irq_i = 1'b1;
                @(posedge clk_i);
                #1;
                irq_i = 1'b0;
            end

            if (step_fails == 0) begin
                passed++;
                $display("ok step %0d pc %h insn %h", i, steps[i].addr, steps[i].insn);
            end else begin
                failed++;
                $display("FAILED at %0t: step %0d had %0d mismatches", $time, i, step_fails);
            end
        end

        $display("Steps passed: %0d, steps failed: %0d, fetch errors: %0d",
                 passed, failed, fetch_errors);
        if (failed == 0 && fetch_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_STEPS * 40 + 200) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", NUM_STEPS * 40 + 200);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: src.f
rv_pkg.sv
insn_if.sv
pc_gen.sv
fetch_fsm.sv
decode_stage.sv
decode_out_reg.sv
rv_frontend_top.sv
rv_frontend_checker.sv
tb_rv_frontend.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rv_frontend
FILELIST  ?= src.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
